//--- compile.f
source/core_pkg.sv
source/pipe_pkg.sv
source/alu_stage.sv
source/ex_mem_reg.sv
source/data_mem_stage.sv
source/exec_backend.sv
dv/backend_checker.sv
dv/backend_props.sv
dv/backend_tb.sv

//--- Bender.yml
package:
  name: exec_backend

sources:
  - source/core_pkg.sv
  - source/pipe_pkg.sv
  - source/alu_stage.sv
  - source/ex_mem_reg.sv
  - source/data_mem_stage.sv
  - source/exec_backend.sv
  - target: test
    files:
      - dv/backend_checker.sv
      - dv/backend_props.sv
      - dv/backend_tb.sv

//--- dv/backend_trace.txt
# stall flush valid pc_4 rt rd imm16 reg_w_en data_a data_b alu_op use_imm dm_op reg_dst wb_sel syscall exp_data
# All hex, enums by position in core_pkg, exp_data is the expected writeback data
0 0 1 00000104 00 03 0000 1 00000005 00000003 0 0 0 1 0 0 00000008
0 0 1 00000108 04 00 fffe 1 00000010 00000000 0 1 0 0 0 0 0000000e
0 0 1 0000010c 00 05 0000 1 0000000a 0000000c 1 0 0 1 0 0 fffffffe
0 0 1 00000110 00 06 0000 1 f0f0f0f0 0ff00ff0 2 0 0 1 0 0 00f000f0
0 0 1 00000114 07 00 ff00 1 12345678 00000000 2 1 0 0 0 0 00005600
0 0 1 00000118 00 08 0000 1 f0000000 0000000f 3 0 0 1 0 0 f000000f
0 0 1 0000011c 09 00 5678 1 12340000 00000000 3 1 0 0 0 0 12345678
0 0 1 00000120 00 0a 0000 1 ffff0000 0f0f0f0f 4 0 0 1 0 0 f0f00f0f
0 0 1 00000124 0b 00 00ff 1 0000ffff 00000000 4 1 0 0 0 0 0000ff00
0 0 1 00000128 00 0c 0000 1 00000000 0000ffff 5 0 0 1 0 0 ffff0000
0 0 1 0000012c 00 0d 0000 1 ffffffff 00000001 6 0 0 1 0 0 00000001
0 0 1 00000130 00 0e 0000 1 ffffffff 00000001 7 0 0 1 0 0 00000000
0 0 1 00000134 0f 00 fff8 1 fffffff0 00000000 6 1 0 0 0 0 00000001
0 0 1 00000138 10 00 ffff 1 00000005 00000000 7 1 0 0 0 0 00000001
0 0 1 0000013c 00 11 0100 1 00000000 00000001 8 0 0 1 0 0 00000010
0 0 1 00000140 00 12 07c0 1 00000000 80000000 9 0 0 1 0 0 00000001
0 0 1 00000144 00 13 0100 1 00000000 80000000 a 0 0 1 0 0 f8000000
0 0 1 00000148 14 00 abcd 1 00000000 00000000 b 1 0 0 0 0 abcd0000
0 0 1 0000014c 00 00 0000 0 00000100 11223344 0 1 8 0 0 0 00000100
0 0 1 00000150 00 00 0001 0 00000100 000000aa 0 1 6 0 0 0 00000101
0 0 1 00000154 00 00 0002 0 00000100 0000beef 0 1 7 0 0 0 00000102
0 0 1 00000158 15 00 0000 1 00000100 00000000 0 1 5 0 1 0 beefaa44
0 0 1 0000015c 16 00 0001 1 00000100 00000000 0 1 1 0 1 0 ffffffaa
0 0 1 00000160 17 00 0001 1 00000100 00000000 0 1 2 0 1 0 000000aa
0 0 1 00000164 18 00 0002 1 00000100 00000000 0 1 3 0 1 0 ffffbeef
0 0 1 00000168 19 00 0002 1 00000100 00000000 0 1 4 0 1 0 0000beef
0 0 1 0000016c 1a 00 0000 1 00000100 00000000 0 1 1 0 1 0 00000044
0 0 1 00000170 1b 00 0003 1 00000100 00000000 0 1 3 0 1 0 ffffbeef
0 0 1 00000174 1c 00 0003 1 00000100 00000000 0 1 2 0 1 0 000000be
0 0 1 00000178 00 00 0000 0 00000200 cafef00d 0 1 8 0 0 0 00000200
1 0 1 0000017c 00 1d 0000 1 00000001 00000002 0 0 0 1 0 0 00000003
1 0 1 0000017c 00 1d 0000 1 00000001 00000002 0 0 0 1 0 0 00000003
0 0 1 0000017c 00 1d 0000 1 00000001 00000002 0 0 0 1 0 0 00000003
0 0 1 00000180 1e 00 0000 1 00000200 00000000 0 1 5 0 1 0 cafef00d
0 0 1 00000184 00 00 0000 0 00000200 deadbeef 0 1 8 0 0 0 00000200
1 1 0 00000000 00 00 0000 0 00000000 00000000 0 0 0 0 0 0 00000000
0 1 1 00000188 00 1f 0000 1 00000007 00000007 0 0 0 1 0 0 0000000e
0 0 1 0000018c 01 00 0000 1 00000200 00000000 0 1 5 0 1 0 cafef00d
0 0 1 00000400 00 00 0000 1 00000000 00000000 0 0 0 2 2 0 00000404
0 0 1 00000404 00 00 0000 0 00000000 00000000 0 0 0 0 0 1 00000000
0 0 0 00000000 00 00 0000 0 00000000 00000000 0 0 0 0 0 0 00000000
0 0 0 00000000 00 00 0000 0 00000000 00000000 0 0 0 0 0 0 00000000

//--- dv/backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module backend_tb
    import core_pkg::*, pipe_pkg::*;
();

    localparam int    dmem_words  = 256;
    localparam int    drain_limit = 20;
    localparam int    field_count = 17;
    localparam string trace_path  = "dv/backend_trace.txt";

    logic              clk = 1'b0;
    logic              rst_n;
    logic              stall;
    logic              flush;
    ex_rec_t           issue;
    logic [data_w-1:0] exp_data;
    wb_rec_t           wb;
    logic              halt;
    logic              busy;
    int                checker_errors;
    int                checks;
    int                tb_errors = 0;
    logic [31:0]       rand_state = 32'd66998;

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Operands of a bubble carry noise, which must never reach writeback
    task automatic fill_operands();
        rand_state   = xorshift32(rand_state);
        issue.data_a = rand_state;
        rand_state   = xorshift32(rand_state);
        issue.data_b = rand_state;
    endtask

    task automatic drive_idle();
        stall    = 1'b0;
        flush    = 1'b0;
        issue    = '0;
        exp_data = '0;
        fill_operands();
    endtask

    task automatic apply_fields(input logic [31:0] f [field_count]);
        stall            = f[0][0];
        flush            = f[1][0];
        issue.valid      = f[2][0];
        issue.pc_4       = f[3];
        issue.rt         = f[4][reg_addr_w-1:0];
        issue.rd         = f[5][reg_addr_w-1:0];
        issue.imm16      = f[6][15:0];
        issue.reg_w_en   = f[7][0];
        issue.data_a     = f[8];
        issue.data_b     = f[9];
        issue.alu_op     = alu_op_e'(f[10][3:0]);
        issue.use_imm    = f[11][0];
        issue.dm_op      = dm_op_e'(f[12][3:0]);
        issue.reg_dst    = reg_dst_e'(f[13][1:0]);
        issue.wb_sel     = wb_sel_e'(f[14][1:0]);
        issue.syscall    = f[15][0];
        issue.pc_guessed = f[3] + 32'd4;  // Carried along, never checked
        exp_data         = f[16];
        if (!issue.valid) begin
            fill_operands();
        end
    endtask

    exec_backend #(
        .dmem_words (dmem_words)
    ) dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .issue (issue),
        .wb    (wb),
        .halt  (halt)
    );

    backend_checker chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .issue       (issue),
        .exp_data    (exp_data),
        .wb          (wb),
        .halt        (halt),
        .busy        (busy),
        .error_count (checker_errors),
        .check_count (checks)
    );

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          wait_cycles;
        int          total;
        string       line;
        logic [31:0] f [field_count];

        rst_n = 1'b0;
        drive_idle();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        line_no = 0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", trace_path);
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) break;
                line_no++;
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (n != field_count) begin
                    $display("Trace line %0d has %0d fields instead of %0d",
                             line_no, n, field_count);
                    tb_errors++;
                    continue;
                end
                @(negedge clk);
                apply_fields(f);
            end
            $fclose(fd);
        end

        // Let the last instructions leave the pipeline
        @(negedge clk);
        drive_idle();
        wait_cycles = 0;
        while (busy && wait_cycles < drain_limit) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (busy) begin
            $display("The pipeline did not drain within %0d cycles", drain_limit);
            tb_errors++;
        end
        repeat (3) @(negedge clk);  // Halt has to stay high

        total = checker_errors + dut0.u_ex_mem.props0.fail_count + tb_errors;
        $display("Checks %0d, mismatches %0d, assertion failures %0d, testbench errors %0d",
                 checks, checker_errors, dut0.u_ex_mem.props0.fail_count, tb_errors);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/backend_props.sv
`timescale 1ns/100ps
`default_nettype none

module backend_props
    import pipe_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     flush,
    input mem_rec_t d,
    input mem_rec_t q
);

    int fail_count = 0;

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !q.valid)
        else begin
            fail_count++;
            $error("EX/MEM still holds a valid record after a flush");
        end

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> $stable(q))
        else begin
            fail_count++;
            $error("EX/MEM changed while stalled");
        end

    // A valid record can only come from a valid record at the input
    valid_from_input: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(q.valid) |-> $past(d.valid))
        else begin
            fail_count++;
            $error("EX/MEM became valid without a valid input record");
        end

endmodule

bind ex_mem_reg backend_props props0 (
    .clk   (clk),
    .rst_n (rst_n),
    .stall (stall),
    .flush (flush),
    .d     (d),
    .q     (q)
);

`default_nettype wire

//--- dv/backend_checker.sv
`timescale 1ns/100ps
`default_nettype none

module backend_checker
    import core_pkg::*, pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  ex_rec_t           issue,
    input  logic [data_w-1:0] exp_data,
    input  wb_rec_t           wb,
    input  logic              halt,
    output logic              busy,
    output int                error_count,
    output int                check_count
);

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_w_en;
        logic                  syscall;
        logic [data_w-1:0]     data;
    } expect_t;

    expect_t stage_q [2];  // Entry 0 mirrors EX/MEM, entry 1 the writeback register
    expect_t incoming;
    logic    exp_halt;
    int      errors = 0;
    int      checks = 0;

    assign busy        = stage_q[0].valid || stage_q[1].valid;
    assign error_count = errors;
    assign check_count = checks;

    always_comb begin
        incoming          = '0;
        incoming.valid    = issue.valid;
        incoming.reg_w_en = issue.reg_w_en;
        incoming.syscall  = issue.syscall;
        incoming.data     = exp_data;  // Expected value comes with the stimulus
        case (issue.reg_dst)
            dst_rt:  incoming.dest = issue.rt;
            dst_rd:  incoming.dest = issue.rd;
            default: incoming.dest = reg_addr_w'(31);
        endcase
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q[0] <= '0;
            stage_q[1] <= '0;
            exp_halt   <= 1'b0;
        end else begin
            // The record in EX/MEM moves on only in a cycle without stall
            if (stage_q[0].valid && !stall) begin
                stage_q[1] <= stage_q[0];
                exp_halt   <= exp_halt || stage_q[0].syscall;
            end else begin
                stage_q[1] <= '0;
            end
            if (flush) begin
                stage_q[0] <= '0;
            end else if (!stall) begin
                stage_q[0] <= incoming;
            end
        end
    end

    task automatic compare(input string name, input logic [data_w-1:0] got,
                           input logic [data_w-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h at %0t ns", name, got, want, $time);
        end
    endtask

    // Outputs settle after the rising edge, so they are compared on the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            compare("wb.valid", data_w'(wb.valid), data_w'(stage_q[1].valid));
            compare("wb.reg_w_en", data_w'(wb.reg_w_en), data_w'(stage_q[1].reg_w_en));
            compare("halt", data_w'(halt), data_w'(exp_halt));
            if (stage_q[1].valid) begin
                compare("wb.dest", data_w'(wb.dest), data_w'(stage_q[1].dest));
                compare("wb.data", wb.data, stage_q[1].data);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/exec_backend.sv
`timescale 1ns/100ps
`default_nettype none

module exec_backend
    import pipe_pkg::*;
#(
    parameter int dmem_words = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    flush,
    input  ex_rec_t issue,
    output wb_rec_t wb,
    output logic    halt
);

    mem_rec_t ex_rec;   // Execute result before the EX/MEM register
    mem_rec_t mem_rec;  // Contents of EX/MEM

    alu_stage u_alu (
        .issue  (issue),
        .ex_out (ex_rec)
    );

    ex_mem_reg u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (ex_rec),
        .q     (mem_rec)
    );

    // The same stall that holds EX/MEM keeps this stage from acting twice
    data_mem_stage #(
        .dmem_words (dmem_words)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .m     (mem_rec),
        .wb    (wb),
        .halt  (halt)
    );

endmodule

`default_nettype wire

//--- source/data_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem_stage
    import core_pkg::*, pipe_pkg::*;
#(
    parameter int dmem_words = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  mem_rec_t m,
    output wb_rec_t  wb,
    output logic     halt
);

    localparam int addr_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [data_w-1:0]     mem [dmem_words];
    logic [addr_w-1:0]     word_idx;
    logic [1:0]            byte_sel;
    logic                  half_sel;
    logic [data_w-1:0]     rd_word;
    logic [7:0]            rd_byte;
    logic [15:0]           rd_half;
    logic [data_w-1:0]     ld_val;
    logic [data_w-1:0]     wr_word;
    logic [data_w-1:0]     wb_value;
    logic                  act;
    logic                  store_en;

    logic                  wb_valid;
    logic                  wb_w_en;
    logic [reg_addr_w-1:0] wb_dest;
    logic [data_w-1:0]     wb_data;

    // Word address wraps around the memory depth
    assign word_idx = addr_w'((m.alu_res >> 2) % dmem_words);
    assign byte_sel = m.alu_res[1:0];
    assign half_sel = m.alu_res[1];  // Bit 0 is ignored for halves

    // A held instruction only acts once the stall lifts
    assign act      = m.valid && !stall;
    assign store_en = act && (m.dm_op inside {dm_sb, dm_sh, dm_sw});

    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[8*byte_sel +: 8];
    assign rd_half = rd_word[16*half_sel +: 16];

    always_comb begin
        case (m.dm_op)
            dm_lb:   ld_val = {{(data_w-8){rd_byte[7]}}, rd_byte};
            dm_lbu:  ld_val = {{(data_w-8){1'b0}}, rd_byte};
            dm_lh:   ld_val = {{(data_w-16){rd_half[15]}}, rd_half};
            dm_lhu:  ld_val = {{(data_w-16){1'b0}}, rd_half};
            default: ld_val = rd_word;
        endcase
    end

    // Partial stores merge into the word already held
    always_comb begin
        wr_word = rd_word;
        case (m.dm_op)
            dm_sb:   wr_word[8*byte_sel +: 8] = m.store_data[7:0];
            dm_sh:   wr_word[16*half_sel +: 16] = m.store_data[15:0];
            default: wr_word = m.store_data;
        endcase
    end

    always_comb begin
        case (m.wb_sel)
            wb_load: wb_value = ld_val;
            wb_link: wb_value = m.pc_4 + pc_w'(4);  // Skips the delay slot
            default: wb_value = m.alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (store_en) begin
            mem[word_idx] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_w_en  <= 1'b0;
            halt     <= 1'b0;
        end else begin
            wb_valid <= act;
            wb_w_en  <= act && m.reg_w_en;
            if (act && m.syscall) begin
                halt <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= m.dest;
        wb_data <= wb_value;
    end

    assign wb = '{valid: wb_valid, dest: wb_dest, reg_w_en: wb_w_en, data: wb_data};

endmodule

`default_nettype wire

//--- source/ex_mem_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_reg
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  mem_rec_t d,
    output mem_rec_t q
);

    // Flush wins over stall, so a stalled instruction can still be squashed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;  // Bubble with valid low
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_stage.sv
`timescale 1ns/100ps
`default_nettype none

module alu_stage
    import core_pkg::*, pipe_pkg::*;
(
    input  ex_rec_t  issue,
    output mem_rec_t ex_out
);

    logic [data_w-1:0]     imm_sext;
    logic [data_w-1:0]     imm_zext;
    logic [data_w-1:0]     op_b;
    logic [data_w-1:0]     alu_res;
    logic [4:0]            shamt;
    logic                  logic_op;
    logic [reg_addr_w-1:0] dest;

    assign imm_sext = {{(data_w-16){issue.imm16[15]}}, issue.imm16};
    assign imm_zext = {{(data_w-16){1'b0}}, issue.imm16};

    // andi, ori and xori take the immediate zero-extended
    assign logic_op = issue.alu_op inside {alu_and, alu_or, alu_xor, alu_nor};

    assign op_b = !issue.use_imm ? issue.data_b : (logic_op ? imm_zext : imm_sext);

    assign shamt = issue.imm16[10:6];  // The sa field of an R-type word

    always_comb begin
        case (issue.alu_op)
            alu_add:  alu_res = issue.data_a + op_b;
            alu_sub:  alu_res = issue.data_a - op_b;
            alu_and:  alu_res = issue.data_a & op_b;
            alu_or:   alu_res = issue.data_a | op_b;
            alu_xor:  alu_res = issue.data_a ^ op_b;
            alu_nor:  alu_res = ~(issue.data_a | op_b);
            alu_slt: begin
                alu_res = {{(data_w-1){1'b0}}, $signed(issue.data_a) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_res = {{(data_w-1){1'b0}}, issue.data_a < op_b};
            end
            // Shifts act on rt, which arrives as data_b
            alu_sll:  alu_res = issue.data_b << shamt;
            alu_srl:  alu_res = issue.data_b >> shamt;
            alu_sra:  alu_res = $signed(issue.data_b) >>> shamt;
            alu_lui:  alu_res = {issue.imm16, {(data_w-16){1'b0}}};
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (issue.reg_dst)
            dst_rt:  dest = issue.rt;
            dst_rd:  dest = issue.rd;
            default: dest = reg_addr_w'(31);  // Link register
        endcase
    end

    always_comb begin
        ex_out            = '0;
        ex_out.valid      = issue.valid;
        ex_out.pc_4       = issue.pc_4;
        ex_out.dest       = dest;
        ex_out.reg_w_en   = issue.reg_w_en;
        ex_out.alu_res    = alu_res;
        ex_out.store_data = issue.data_b;
        ex_out.dm_op      = issue.dm_op;
        ex_out.wb_sel     = issue.wb_sel;
        ex_out.syscall    = issue.syscall;
        ex_out.pc_guessed = issue.pc_guessed;
    end

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import core_pkg::*;

    // Decoded instruction as it enters execute with its operands already read
    typedef struct packed {
        logic                  valid;
        logic [pc_w-1:0]       pc_4;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [15:0]           imm16;
        logic                  reg_w_en;
        logic [data_w-1:0]     data_a;
        logic [data_w-1:0]     data_b;
        alu_op_e               alu_op;
        logic                  use_imm;
        dm_op_e                dm_op;
        reg_dst_e              reg_dst;
        wb_sel_e               wb_sel;
        logic                  syscall;
        logic [pc_w-1:0]       pc_guessed;
    } ex_rec_t;

    typedef struct packed {
        logic                  valid;
        logic [pc_w-1:0]       pc_4;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_w_en;
        logic [data_w-1:0]     alu_res;     // Also the data memory byte address
        logic [data_w-1:0]     store_data;
        dm_op_e                dm_op;
        wb_sel_e               wb_sel;
        logic                  syscall;
        logic [pc_w-1:0]       pc_guessed;
    } mem_rec_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_w_en;
        logic [data_w-1:0]     data;
    } wb_rec_t;

endpackage

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    parameter int data_w = 32;     // Integer word width
    parameter int pc_w = 32;       // Instruction address width
    parameter int reg_addr_w = 5;  // Register file index width

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // Loads come before stores so the store group stays contiguous
    typedef enum logic [3:0] {
        dm_none,
        dm_lb,
        dm_lbu,
        dm_lh,
        dm_lhu,
        dm_lw,
        dm_sb,
        dm_sh,
        dm_sw
    } dm_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link   // Return address for jal and jalr
    } wb_sel_e;

    typedef enum logic [1:0] {
        dst_rt,
        dst_rd,
        dst_r31
    } reg_dst_e;

endpackage

`default_nettype wire
